// File: dv/mem_test_trace.txt
# name mode(reset|cont) word(0-3|none) xor_mask nbytes byte0..byte7, all hex
# Byte slots past nbytes are padding.
clean_b0 reset none 0000 8 00 00 00 00 00 00 00 00
clean_b1 cont none 0000 8 00 01 00 01 00 01 00 01
clean_b2 cont none 0000 8 00 02 00 02 00 02 00 02
clean_b3 cont none 0000 8 00 03 00 03 00 03 00 03
pre_err_b0 reset none 0000 8 00 00 00 00 00 00 00 00
err_w2_b1 cont 2 0100 5 00 01 00 01 ee 00 00 00
err_w0_b0 reset 0 0001 1 ee 00 00 00 00 00 00 00
err_w3_b0 reset 3 8000 7 00 00 00 00 00 00 ee 00

// File: all.f
+incdir+include
hdl/mem_test_pkg.sv
hdl/uart_tx.sv
hdl/burst_report.sv
hdl/burst_test_seq.sv
hdl/mem_test_top.sv
dv/mem_test_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the memory burst self-test with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mem_test_tb -f all.f -o mem_test_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/mem_test_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// File: dv/mem_test_tb.sv
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module mem_test_tb;

    localparam int FRAME_CYC = 11 * `MT_BAUD_DIV;       // One serial frame.
    localparam int LAST_BURST = `MT_ADDR_LIMIT / 4 - 1; // Index of the final burst.

    logic                   clk_133MHz_210;
    logic                   rst_n;
    mem_test_pkg::mem_req_t mem_req;
    mem_test_pkg::mem_rsp_t mem_rsp;
    logic                   txd;
    logic                   err_led;
    logic                   test_done;

    // Trace columns. One entry per burst.
    string       t_name[$];
    string       t_mode[$];
    int          t_word[$];  // 4 when nothing is corrupted.
    logic [15:0] t_mask[$];
    int          t_nbytes[$];
    logic [7:0]  t_bytes[$]; // Eight slots per burst.

    int         n_loaded;
    int         scen_base; // Trace line of the current scenario's first burst.
    int         req_count; // Requests answered by the memory model.
    int         err_cnt;
    logic [7:0] rx_q[$];   // Bytes decoded from txd.
    mem_test_pkg::burst_t mem_store [logic [`MT_ADDR_W-1:0]];

    mem_test_top dut0 (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp),
        .txd            (txd),
        .err_led        (err_led),
        .test_done      (test_done)
    );

    always #2 clk_133MHz_210 = ~clk_133MHz_210; // 4 ns period.

    function automatic void report_mismatch(string sig, logic [63:0] got, logic [63:0] exp);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", sig, got, exp);
        err_cnt++;
    endfunction

    ////////////////////
    // Memory model.
    ////////////////////

    initial begin : memory_model
        int                   lat;
        int                   n;  // Bursts read back since reset.
        int                   ln;
        mem_test_pkg::burst_t rd;
        void'($urandom(32'h270a));
        mem_rsp   = '0;
        lat       = 0;
        n         = 0;
        req_count = 0;
        forever begin
            @(negedge clk_133MHz_210);
            mem_rsp.wr_done = 1'b0; // Done is a single pulse.
            mem_rsp.rd_done = 1'b0;
            if (!rst_n) begin
                lat = 0;
                n   = 0;
            end else if (mem_req.wr_req || mem_req.rd_req) begin
                if (lat == 0) lat = $urandom_range(8, 1); // New request. Waits 1 to 8 cycles.
                lat--;
                if (lat == 0) begin
                    req_count++;
                    ln = scen_base + n;
                    if (mem_req.wr_req) begin
                        if (mem_req.addr !== 4 * n) begin
                            report_mismatch("mem_req.addr", mem_req.addr, 4 * n);
                        end
                        for (int k = 0; k < 4; k++) begin
                            if (mem_req.wdata.words[k] !== n) begin
                                report_mismatch("mem_req.wdata", mem_req.wdata.words[k], n);
                            end
                        end
                        mem_store[mem_req.addr] = mem_req.wdata;
                        mem_rsp.wr_done = 1'b1;
                    end else begin
                        rd = mem_store[mem_req.addr];
                        if (ln < n_loaded && t_word[ln] < 4) rd.words[t_word[ln]] ^= t_mask[ln];
                        mem_rsp.rdata   = rd;
                        mem_rsp.rd_done = 1'b1;
                        n++;
                    end
                end
            end
        end
    end

    // UART decoder. Samples each bit near its middle.
    always begin : uart_rx
        logic [7:0] rx;
        @(negedge txd);
        repeat (`MT_BAUD_DIV / 2) @(negedge clk_133MHz_210);
        for (int i = 0; i < 8; i++) begin
            repeat (`MT_BAUD_DIV) @(negedge clk_133MHz_210);
            rx[i] = txd; // LSB first.
        end
        repeat (`MT_BAUD_DIV) @(negedge clk_133MHz_210);
        if (txd !== 1'b1) begin
            $display("Serial frame is missing its stop bit");
            err_cnt++;
        end
        rx_q.push_back(rx);
    end

    task automatic apply_reset();
        logic seen;
        @(negedge clk_133MHz_210);
        rst_n = 1'b0;
        rx_q.delete();
        repeat (10) @(negedge clk_133MHz_210);
        rst_n = 1'b1;
        if (mem_req.wr_req !== 1'b0) report_mismatch("mem_req.wr_req", mem_req.wr_req, 0);
        if (mem_req.rd_req !== 1'b0) report_mismatch("mem_req.rd_req", mem_req.rd_req, 0);
        if (err_led !== 1'b0) report_mismatch("err_led", err_led, 0);
        if (test_done !== 1'b0) report_mismatch("test_done", test_done, 0);
        if (txd !== 1'b1) report_mismatch("txd", txd, 1);
        seen = 1'b0;
        repeat (2) begin
            @(negedge clk_133MHz_210);
            seen |= mem_req.wr_req; // First write may finish fast.
        end
        if (!seen) begin
            $display("No write request within 2 cycles of reset release");
            err_cnt++;
        end
    endtask

    // Port and line stay silent once halted.
    task automatic check_quiet();
        int reqs;
        reqs = req_count;
        repeat (2 * `MT_PAUSE_CYCLES + FRAME_CYC) @(negedge clk_133MHz_210);
        if (req_count != reqs) begin
            $display("Memory requests appeared after the run stopped");
            err_cnt++;
        end
        if (rx_q.size() != 0) begin
            $display("Extra bytes appeared on txd after the run stopped");
            err_cnt++;
        end
    endtask

    ////////////////////
    // Trace load and run.
    ////////////////////

    initial begin : main
        string       line;
        string       nm;
        string       mode;
        string       ws;
        logic [15:0] mask;
        logic [7:0]  b [8];
        logic [7:0]  got;
        int          fd;
        int          nb;
        int          burst_idx;
        int          errs_before;
        int          n_pass;
        int          n_fail;
        clk_133MHz_210 = 1'b0;
        rst_n          = 1'b0;
        err_cnt        = 0;
        n_loaded       = 0;
        scen_base      = 0;
        burst_idx      = 0;
        n_pass         = 0;
        n_fail         = 0;
        fd = $fopen("dv/mem_test_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file");
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line[0] == "#") continue; // Blank or comment.
                if ($sscanf(line, "%s %s %s %h %d %h %h %h %h %h %h %h %h", nm, mode, ws, mask,
                            nb, b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]) != 13) begin
                    $display("Malformed trace line: %s", line);
                    err_cnt++;
                    continue;
                end
                t_name.push_back(nm);
                t_mode.push_back(mode);
                t_word.push_back((ws == "none") ? 4 : ws.atoi());
                t_mask.push_back(mask);
                t_nbytes.push_back(nb);
                for (int k = 0; k < 8; k++) t_bytes.push_back(b[k]);
            end
            $fclose(fd);
        end
        if (t_name.size() == 0) begin
            $display("The trace holds no tests");
            err_cnt++;
        end
        n_loaded = t_name.size(); // Starts the watchdog.

        for (int i = 0; i < n_loaded; i++) begin
            errs_before = err_cnt;
            if (t_mode[i] == "reset") begin
                scen_base = i;
                burst_idx = 0;
                apply_reset();
            end else begin
                burst_idx++;
            end
            while (rx_q.size() < t_nbytes[i]) @(negedge clk_133MHz_210);
            for (int k = 0; k < t_nbytes[i]; k++) begin
                got = rx_q.pop_front();
                if (got !== t_bytes[8 * i + k]) begin
                    report_mismatch("txd byte", got, t_bytes[8 * i + k]);
                end
            end
            if (t_word[i] < 4) begin
                while (!err_led) @(negedge clk_133MHz_210); // Error stop.
                if (test_done !== 1'b0) report_mismatch("test_done", test_done, 0);
                check_quiet();
            end else if (burst_idx == LAST_BURST) begin
                while (!test_done && !err_led) @(negedge clk_133MHz_210);
                if (err_led !== 1'b0) report_mismatch("err_led", err_led, 0);
                check_quiet();
            end else begin
                if (err_led !== 1'b0) report_mismatch("err_led", err_led, 0);
                if (test_done !== 1'b0) report_mismatch("test_done", test_done, 0);
            end
            if (err_cnt == errs_before) begin
                n_pass++;
                $display("%s: ok", t_name[i]);
            end else begin
                n_fail++;
                $display("%s: %0d error(s)", t_name[i], err_cnt - errs_before);
            end
        end

        $display("Tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Budget per burst is 24 frames plus slack.
    initial begin : watchdog
        wait (n_loaded > 0);
        repeat (n_loaded * (24 * FRAME_CYC + 100)) @(posedge clk_133MHz_210);
        $display("Timeout: the run did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

// File: hdl/mem_test_top.sv
`timescale 1ns/1ps

module mem_test_top (
    input  logic                   clk_133MHz_210,
    input  logic                   rst_n,
    output mem_test_pkg::mem_req_t mem_req,   // To the external memory.
    input  mem_test_pkg::mem_rsp_t mem_rsp,   // From the external memory.
    output logic                   txd,       // Serial report, idle high.
    output logic                   err_led,   // Sticky mismatch lamp.
    output logic                   test_done  // Sticky pass flag.
);

    // Sequencer to reporter.
    mem_test_pkg::report_req_t rpt_req;
    mem_test_pkg::report_rsp_t rpt_rsp;

    // Reporter to serializer.
    logic [7:0] tx_byte;
    logic       byte_valid;
    logic       ready;

    ////////////////////
    // Burst sequencer.
    ////////////////////

    burst_test_seq u_seq (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp),
        .rpt_req        (rpt_req),
        .rpt_rsp        (rpt_rsp),
        .err_led        (err_led),
        .test_done      (test_done)
    );

    ////////////////////
    // Word compare and byte select.
    ////////////////////

    burst_report u_report (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .rpt_req        (rpt_req),
        .rpt_rsp        (rpt_rsp),
        .tx_byte        (tx_byte),
        .byte_valid     (byte_valid),
        .ready          (ready)
    );

    ////////////////////
    // Serial line.
    ////////////////////

    uart_tx u_uart (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .tx_byte        (tx_byte),
        .byte_valid     (byte_valid),
        .ready          (ready),
        .txd            (txd)
    );

endmodule

// File: hdl/burst_test_seq.sv
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module burst_test_seq (
    input  logic                      clk_133MHz_210,
    input  logic                      rst_n,
    output mem_test_pkg::mem_req_t    mem_req,
    input  mem_test_pkg::mem_rsp_t    mem_rsp,
    output mem_test_pkg::report_req_t rpt_req,
    input  mem_test_pkg::report_rsp_t rpt_rsp,
    output logic                      err_led,
    output logic                      test_done
);

    localparam int ADDR_W  = `MT_ADDR_W;
    localparam int PAUSE_W = $clog2(`MT_PAUSE_CYCLES);

    // State encodings.
    localparam logic [2:0] S_WRITE  = 3'd0;
    localparam logic [2:0] S_READ   = 3'd1;
    localparam logic [2:0] S_REPORT = 3'd2;
    localparam logic [2:0] S_PAUSE  = 3'd3;
    localparam logic [2:0] S_STEP   = 3'd4;
    localparam logic [2:0] S_HALT   = 3'd5;

    logic [2:0]                 state;
    logic                       wr_req;
    logic                       rd_req;
    logic [ADDR_W-1:0]          addr;      // Burst base address.
    mem_test_pkg::burst_t       wdata;     // Pattern written, also the expected one.
    mem_test_pkg::burst_t       rdata;     // Burst read back.
    logic                       rpt_start;
    logic [PAUSE_W-1:0]         pause_cnt;

    assign mem_req = '{wr_req: wr_req, rd_req: rd_req, addr: addr, wdata: wdata};
    assign rpt_req = '{start: rpt_start, expected: wdata, actual: rdata};

    // Read capture. Held through the report.
    always_ff @(posedge clk_133MHz_210) begin
        if (mem_rsp.rd_done) begin
            rdata <= mem_rsp.rdata;
        end
    end

    ////////////////////
    // Main FSM.
    ////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_WRITE;
            wr_req    <= 1'b0;
            rd_req    <= 1'b0;
            addr      <= '0;
            wdata     <= '0;
            rpt_start <= 1'b0;
            pause_cnt <= '0;
            err_led   <= 1'b0;
            test_done <= 1'b0;
        end else begin
            rpt_start <= 1'b0; // Pulse only.
            case (state)
                S_WRITE: begin
                    if (mem_rsp.wr_done) begin
                        wr_req <= 1'b0; // Drop the cycle after done.
                        state  <= S_READ;
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                S_READ: begin
                    if (mem_rsp.rd_done) begin
                        rd_req    <= 1'b0;
                        rpt_start <= 1'b1; // rdata lands on the same edge.
                        state     <= S_REPORT;
                    end else begin
                        rd_req <= 1'b1;
                    end
                end
                S_REPORT: begin
                    if (rpt_rsp.done) begin
                        if (rpt_rsp.fail) begin
                            err_led <= 1'b1; // Stop for good.
                            state   <= S_HALT;
                        end else begin
                            pause_cnt <= '0;
                            state     <= S_PAUSE;
                        end
                    end
                end
                S_PAUSE: begin
                    if (pause_cnt == PAUSE_W'(`MT_PAUSE_CYCLES - 1)) begin
                        state <= S_STEP;
                    end else begin
                        pause_cnt <= pause_cnt + 1'b1;
                    end
                end
                S_STEP: begin
                    // Last burst passed.
                    if (addr == ADDR_W'(`MT_ADDR_LIMIT - 4)) begin
                        test_done <= 1'b1;
                        state     <= S_HALT;
                    end else begin
                        addr <= addr + ADDR_W'(4); // Next burst slot.
                        for (int i = 0; i < 4; i++) begin
                            wdata.words[i] <= wdata.words[i] + 1'b1;
                        end
                        wr_req <= 1'b1;
                        state  <= S_WRITE;
                    end
                end
                default: begin
                    state <= S_HALT; // Halted, port stays quiet.
                end
            endcase
        end
    end

endmodule

// File: hdl/burst_report.sv
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module burst_report (
    input  logic                      clk_133MHz_210,
    input  logic                      rst_n,
    input  mem_test_pkg::report_req_t rpt_req,
    output mem_test_pkg::report_rsp_t rpt_rsp,
    output logic [7:0]                tx_byte,
    output logic                      byte_valid,
    input  logic                      ready
);

    // State encodings.
    localparam logic [2:0] R_IDLE  = 3'd0;
    localparam logic [2:0] R_CHECK = 3'd1;
    localparam logic [2:0] R_HI    = 3'd2; // High byte offered.
    localparam logic [2:0] R_LO    = 3'd3; // Low byte offered.
    localparam logic [2:0] R_ERR   = 3'd4; // Error code offered.

    logic [2:0] state;
    logic [1:0] widx;   // Word under test.
    logic       done_q;
    logic       fail_q;
    logic       accept; // Byte taken by the serializer.

    assign accept  = byte_valid && ready;
    assign rpt_rsp = '{done: done_q, fail: fail_q};

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state      <= R_IDLE;
            widx       <= '0;
            tx_byte    <= '0;
            byte_valid <= 1'b0;
            done_q     <= 1'b0;
            fail_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (rpt_req.start) begin
                        widx  <= '0;
                        state <= R_CHECK;
                    end
                end
                R_CHECK: begin
                    byte_valid <= 1'b1;
                    if (rpt_req.actual.words[widx] == rpt_req.expected.words[widx]) begin
                        tx_byte <= rpt_req.actual.bytes[{widx, 1'b1}]; // High byte first.
                        state   <= R_HI;
                    end else begin
                        tx_byte <= `MT_ERR_BYTE;
                        state   <= R_ERR;
                    end
                end
                R_HI: begin
                    if (accept) begin
                        tx_byte <= rpt_req.actual.bytes[{widx, 1'b0}]; // Keep valid up.
                        state   <= R_LO;
                    end
                end
                R_LO: begin
                    if (accept) begin
                        byte_valid <= 1'b0;
                        if (widx == 2'd3) begin
                            done_q <= 1'b1; // Clean burst.
                            fail_q <= 1'b0;
                            state  <= R_IDLE;
                        end else begin
                            widx  <= widx + 1'b1;
                            state <= R_CHECK;
                        end
                    end
                end
                R_ERR: begin
                    // Done only once 0xEE has gone.
                    if (accept) begin
                        byte_valid <= 1'b0;
                        done_q     <= 1'b1;
                        fail_q     <= 1'b1;
                        state      <= R_IDLE;
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`include "mem_test_defs.svh"

module uart_tx (
    input  logic       clk_133MHz_210,
    input  logic       rst_n,
    input  logic [7:0] tx_byte,
    input  logic       byte_valid,
    output logic       ready,
    output logic       txd
);

    localparam int BAUD_W = $clog2(`MT_BAUD_DIV);

    logic [10:0]       frame;    // Two stop, eight data, one start. LSB goes out first.
    logic [3:0]        bit_cnt;  // Bit on the line.
    logic [BAUD_W-1:0] baud_cnt; // Cycles within the bit.
    logic              busy;

    assign ready = !busy;
    assign txd   = frame[0]; // Ones refill behind the shift, so idle stays high.

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            frame    <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
            busy     <= 1'b0;
        end else if (!busy) begin
            if (byte_valid) begin
                frame    <= {2'b11, tx_byte, 1'b0};
                bit_cnt  <= '0;
                baud_cnt <= '0;
                busy     <= 1'b1;
            end
        end else begin
            if (baud_cnt == BAUD_W'(`MT_BAUD_DIV - 1)) begin
                baud_cnt <= '0;
                frame    <= {1'b1, frame[10:1]}; // Next bit.
                if (bit_cnt == 4'd10) begin
                    busy <= 1'b0; // Last stop bit done.
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/mem_test_pkg.sv
`include "mem_test_defs.svh"

package mem_test_pkg;

    // One four-word burst. Word 0 and byte 0 sit in the low bits.
    typedef union packed {
        logic [3:0][`MT_WORD_W-1:0] words; // Compare view.
        logic [7:0][7:0]            bytes; // Report view.
    } burst_t;

    ////////////////////
    // Memory port.
    ////////////////////

    typedef struct packed {
        logic                  wr_req; // Held until wr_done.
        logic                  rd_req; // Held until rd_done.
        logic [`MT_ADDR_W-1:0] addr;
        burst_t                wdata;
    } mem_req_t;

    typedef struct packed {
        logic   wr_done; // One-cycle pulse.
        logic   rd_done; // One-cycle pulse, rdata valid here.
        burst_t rdata;
    } mem_rsp_t;

    ////////////////////
    // Report handshake.
    ////////////////////

    typedef struct packed {
        logic   start;    // One-cycle pulse.
        burst_t expected; // Stable until done.
        burst_t actual;   // Stable until done.
    } report_req_t;

    typedef struct packed {
        logic done; // One-cycle pulse.
        logic fail; // Valid with done.
    } report_rsp_t;

endpackage

// File: include/mem_test_defs.svh
`ifndef MEM_TEST_DEFS_SVH
`define MEM_TEST_DEFS_SVH

////////////////////
// Serial line.
////////////////////

// Clock cycles per serial bit. 1157 gives 115200 baud at 133 MHz.
`define MT_BAUD_DIV 8

////////////////////
// Burst sequencing.
////////////////////

`define MT_PAUSE_CYCLES 20 // Idle gap after each good burst.
`define MT_ADDR_LIMIT 16   // Last burst sits at this address minus 4.
`define MT_ERR_BYTE 8'hEE  // Sent in place of a failing word.

////////////////////
// Memory port.
////////////////////

`define MT_ADDR_W 24 // Bank, row and column.
`define MT_WORD_W 16 // One memory word.

`endif
